/* hw/ext_mem_pkg.sv */
package ext_mem_pkg;

   // Bus widths shared by both front ends and the memory port
   localparam int ADDR_W = 16;  // Byte address
   localparam int DATA_W = 32;

   typedef logic [DATA_W-1:0]   word_t;
   typedef logic [DATA_W/8-1:0] strb_t;  // One bit per byte lane
   typedef logic [ADDR_W-1:0]   addr_t;

   // Back-end master slots in the merge
   localparam logic MASTER_I = 1'b0;  // Instruction cache
   localparam logic MASTER_D = 1'b1;  // Data cache

endpackage

/* hw/fe_port.sv */
`timescale 1ns/1ps

module fe_port (
   input  logic               clk_i,
   input  logic               arst_i,
   input  logic               req_i,
   input  ext_mem_pkg::addr_t addr_i,
   input  ext_mem_pkg::word_t wdata_i,
   input  ext_mem_pkg::strb_t wstrb_i,
   input  logic               ack_i,    // From cache
   input  ext_mem_pkg::word_t crdata_i,
   output logic               ready_o,
   output logic               rvalid_o,
   output ext_mem_pkg::word_t rdata_o,
   output logic               creq_o,   // Held until ack
   output ext_mem_pkg::addr_t caddr_o,
   output ext_mem_pkg::word_t cwdata_o,
   output ext_mem_pkg::strb_t cwstrb_o
);
   import ext_mem_pkg::*;

   logic  pend_q;   // Access captured, waiting on cache
   logic  wr_q;     // Captured access is a write
   addr_t addr_q;
   word_t wdata_q;
   strb_t wstrb_q;

   // New request only taken when nothing is pending
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         pend_q <= 1'b0;
         wr_q   <= 1'b0;
      end else if (!pend_q && req_i) begin
         pend_q <= 1'b1;
         wr_q   <= |wstrb_i;  // Nonzero strobe means write
      end else if (ack_i) begin
         pend_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!pend_q && req_i) begin
         addr_q  <= addr_i;
         wdata_q <= wdata_i;
         wstrb_q <= wstrb_i;
      end
   end

   // Drop request in the ack cycle so the cache does not restart
   assign creq_o   = pend_q & ~ack_i;
   assign caddr_o  = addr_q;
   assign cwdata_o = wdata_q;
   assign cwstrb_o = wstrb_q;

   assign ready_o  = ack_i;
   assign rvalid_o = ack_i & ~wr_q;  // No read data on writes
   assign rdata_o  = crdata_i;

endmodule

/* hw/dm_cache.sv */
`timescale 1ns/1ps

module dm_cache #(
   parameter int NLINES_W      = 4,  // Index bits
   parameter int WRITE_THROUGH = 0   // 1 lets writes through to the back end
) (
   input  logic               clk_i,
   input  logic               arst_i,
   input  logic               req_i,
   input  ext_mem_pkg::addr_t addr_i,   // Held by adapter until ack
   input  ext_mem_pkg::word_t wdata_i,
   input  ext_mem_pkg::strb_t wstrb_i,
   input  logic               invalidate_i,
   input  logic               be_ack_i,
   input  ext_mem_pkg::word_t be_rdata_i,
   output logic               ack_o,
   output ext_mem_pkg::word_t rdata_o,
   output logic               be_req_o,
   output ext_mem_pkg::addr_t be_addr_o,
   output ext_mem_pkg::word_t be_wdata_o,
   output ext_mem_pkg::strb_t be_wstrb_o
);
   import ext_mem_pkg::*;

   localparam int NLINES = 1 << NLINES_W;
   localparam int TAG_W  = ADDR_W - NLINES_W - 2;  // Above index and byte offset

   typedef enum logic [1:0] {
      S_IDLE,
      S_LOOKUP,
      S_FILL,
      S_WRITE
   } state_t;

   state_t              state_q;
   logic                be_req_q;
   logic                ack_q;
   logic                inv_pend_q;  // Invalidate seen during a back-end access
   logic [NLINES-1:0]   valid_q;
   logic [TAG_W-1:0]    tag_q [NLINES];
   word_t               data_q [NLINES];
   word_t               rdata_q;

   logic [NLINES_W-1:0] idx;
   logic [TAG_W-1:0]    tag;
   logic                hit;
   logic                is_wr;

   assign idx   = addr_i[NLINES_W+1:2];
   assign tag   = addr_i[ADDR_W-1:NLINES_W+2];
   assign hit   = valid_q[idx] && (tag_q[idx] == tag);
   assign is_wr = (WRITE_THROUGH != 0) && (|wstrb_i);  // I-side never writes

   // Control FSM and valid bits
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q    <= S_IDLE;
         be_req_q   <= 1'b0;
         ack_q      <= 1'b0;
         inv_pend_q <= 1'b0;
         valid_q    <= '0;
      end else begin
         ack_q <= 1'b0;  // Single-cycle pulse
         case (state_q)
            S_IDLE: begin
               if (req_i) state_q <= S_LOOKUP;
            end
            S_LOOKUP: begin
               if (is_wr) begin
                  be_req_q <= 1'b1;  // Writes always reach memory
                  state_q  <= S_WRITE;
               end else if (hit) begin
                  ack_q   <= 1'b1;
                  state_q <= S_IDLE;
               end else begin
                  be_req_q <= 1'b1;  // Fetch the word on a miss
                  state_q  <= S_FILL;
               end
            end
            S_FILL: begin
               if (be_ack_i) begin
                  be_req_q     <= 1'b0;
                  valid_q[idx] <= 1'b1;
                  ack_q        <= 1'b1;
                  state_q      <= S_IDLE;
               end
            end
            S_WRITE: begin
               if (be_ack_i) begin
                  be_req_q <= 1'b0;
                  ack_q    <= 1'b1;
                  state_q  <= S_IDLE;
               end
            end
            default: state_q <= S_IDLE;
         endcase

         // Invalidate waits for the back end to go idle
         if (be_req_q) begin
            if (invalidate_i) inv_pend_q <= 1'b1;
         end else if (invalidate_i || inv_pend_q) begin
            valid_q    <= '0;
            inv_pend_q <= 1'b0;
         end
      end
   end

   // Tag and data arrays and the read data register
   always_ff @(posedge clk_i) begin
      if (state_q == S_LOOKUP && !is_wr && hit) begin
         rdata_q <= data_q[idx];
      end
      if (state_q == S_FILL && be_ack_i) begin
         data_q[idx] <= be_rdata_i;
         tag_q[idx]  <= tag;
         rdata_q     <= be_rdata_i;  // Forward fill word
      end else if (state_q == S_WRITE && be_ack_i && hit) begin
         for (int b = 0; b < DATA_W/8; b++) begin
            if (wstrb_i[b]) data_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];  // Byte merge on hit
         end
      end
   end

   assign ack_o   = ack_q;
   assign rdata_o = rdata_q;

   // Back-end fields come straight from the held request
   assign be_req_o   = be_req_q;
   assign be_addr_o  = {addr_i[ADDR_W-1:2], 2'b00};  // Word aligned
   assign be_wdata_o = wdata_i;
   assign be_wstrb_o = is_wr ? wstrb_i : '0;

endmodule

/* hw/be_merge.sv */
`timescale 1ns/1ps

module be_merge (
   input  logic               clk_i,
   input  logic               arst_i,
   input  logic [1:0]         m_req_i,
   input  ext_mem_pkg::addr_t m_addr_i  [2],
   input  ext_mem_pkg::word_t m_wdata_i [2],
   input  ext_mem_pkg::strb_t m_wstrb_i [2],
   input  logic               mem_ack_i,
   input  ext_mem_pkg::word_t mem_rdata_i,
   output logic [1:0]         m_ack_o,
   output ext_mem_pkg::word_t m_rdata_o [2],
   output logic               mem_req_o,
   output ext_mem_pkg::addr_t mem_addr_o,
   output ext_mem_pkg::word_t mem_wdata_o,
   output ext_mem_pkg::strb_t mem_wstrb_o
);
   import ext_mem_pkg::*;

   logic busy_q;  // Grant held until ack
   logic gnt_q;   // Owner of the memory port
   logic rr_q;    // Master with priority next
   logic sel;

   // Priority master wins if requesting, else the other
   assign sel = m_req_i[rr_q] ? rr_q : ~rr_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         busy_q <= 1'b0;
         gnt_q  <= MASTER_I;
         rr_q   <= MASTER_I;  // I-side first after reset
      end else if (!busy_q) begin
         if (|m_req_i) begin
            busy_q <= 1'b1;
            gnt_q  <= sel;
         end
      end else if (mem_ack_i) begin
         busy_q <= 1'b0;
         rr_q   <= ~gnt_q;  // Alternate on every ack
      end
   end

   assign mem_req_o   = busy_q;
   assign mem_addr_o  = m_addr_i[gnt_q];
   assign mem_wdata_o = m_wdata_i[gnt_q];
   assign mem_wstrb_o = m_wstrb_i[gnt_q];

   // Ack and read data only to the owner
   always_comb begin
      m_ack_o        = 2'b00;
      m_ack_o[gnt_q] = busy_q & mem_ack_i;
      m_rdata_o[MASTER_I] = (gnt_q == MASTER_I) ? mem_rdata_i : '0;
      m_rdata_o[MASTER_D] = (gnt_q == MASTER_D) ? mem_rdata_i : '0;
   end

endmodule

/* hw/ext_mem.sv */
`timescale 1ns/1ps

module ext_mem #(
   parameter int NLINES_W = 4  // Same depth for both caches
) (
   input  logic               clk_i,
   input  logic               arst_i,
   input  logic               invalidate_i,
   // Instruction port, read only
   input  logic               i_req_i,
   input  ext_mem_pkg::addr_t i_addr_i,
   output logic               i_ready_o,
   output logic               i_rvalid_o,
   output ext_mem_pkg::word_t i_rdata_o,
   // Data port
   input  logic               d_req_i,
   input  ext_mem_pkg::addr_t d_addr_i,
   input  ext_mem_pkg::word_t d_wdata_i,
   input  ext_mem_pkg::strb_t d_wstrb_i,
   output logic               d_ready_o,
   output logic               d_rvalid_o,
   output ext_mem_pkg::word_t d_rdata_o,
   // Native memory port
   output logic               mem_req_o,
   output ext_mem_pkg::addr_t mem_addr_o,
   output ext_mem_pkg::word_t mem_wdata_o,
   output ext_mem_pkg::strb_t mem_wstrb_o,
   input  logic               mem_ack_i,
   input  ext_mem_pkg::word_t mem_rdata_i
);
   import ext_mem_pkg::*;

   // Adapter to cache links per port
   logic  i_creq, d_creq;
   addr_t i_caddr, d_caddr;
   word_t i_cwdata, d_cwdata;
   strb_t i_cwstrb, d_cwstrb;
   logic  i_cack, d_cack;
   word_t i_crdata, d_crdata;

   // Cache back ends indexed by master slot
   logic [1:0] be_req;
   logic [1:0] be_ack;
   addr_t      be_addr  [2];
   word_t      be_wdata [2];
   strb_t      be_wstrb [2];
   word_t      be_rdata [2];

   fe_port i_fe_port (
      .clk_i(clk_i), .arst_i(arst_i),
      .req_i(i_req_i), .addr_i(i_addr_i),
      .wdata_i('0), .wstrb_i('0),  // I-side never writes
      .ack_i(i_cack), .crdata_i(i_crdata),
      .ready_o(i_ready_o), .rvalid_o(i_rvalid_o), .rdata_o(i_rdata_o),
      .creq_o(i_creq), .caddr_o(i_caddr), .cwdata_o(i_cwdata), .cwstrb_o(i_cwstrb)
   );

   fe_port d_fe_port (
      .clk_i(clk_i), .arst_i(arst_i),
      .req_i(d_req_i), .addr_i(d_addr_i),
      .wdata_i(d_wdata_i), .wstrb_i(d_wstrb_i),
      .ack_i(d_cack), .crdata_i(d_crdata),
      .ready_o(d_ready_o), .rvalid_o(d_rvalid_o), .rdata_o(d_rdata_o),
      .creq_o(d_creq), .caddr_o(d_caddr), .cwdata_o(d_cwdata), .cwstrb_o(d_cwstrb)
   );

   dm_cache #(.NLINES_W(NLINES_W), .WRITE_THROUGH(0)) i_icache (
      .clk_i(clk_i), .arst_i(arst_i),
      .req_i(i_creq), .addr_i(i_caddr), .wdata_i(i_cwdata), .wstrb_i(i_cwstrb),
      .invalidate_i(invalidate_i),
      .be_ack_i(be_ack[MASTER_I]), .be_rdata_i(be_rdata[MASTER_I]),
      .ack_o(i_cack), .rdata_o(i_crdata),
      .be_req_o(be_req[MASTER_I]), .be_addr_o(be_addr[MASTER_I]),
      .be_wdata_o(be_wdata[MASTER_I]), .be_wstrb_o(be_wstrb[MASTER_I])
   );

   dm_cache #(.NLINES_W(NLINES_W), .WRITE_THROUGH(1)) d_dcache (
      .clk_i(clk_i), .arst_i(arst_i),
      .req_i(d_creq), .addr_i(d_caddr), .wdata_i(d_cwdata), .wstrb_i(d_cwstrb),
      .invalidate_i(invalidate_i),
      .be_ack_i(be_ack[MASTER_D]), .be_rdata_i(be_rdata[MASTER_D]),
      .ack_o(d_cack), .rdata_o(d_crdata),
      .be_req_o(be_req[MASTER_D]), .be_addr_o(be_addr[MASTER_D]),
      .be_wdata_o(be_wdata[MASTER_D]), .be_wstrb_o(be_wstrb[MASTER_D])
   );

   be_merge i_be_merge (
      .clk_i(clk_i), .arst_i(arst_i),
      .m_req_i(be_req), .m_addr_i(be_addr), .m_wdata_i(be_wdata), .m_wstrb_i(be_wstrb),
      .mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i),
      .m_ack_o(be_ack), .m_rdata_o(be_rdata),
      .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o),
      .mem_wdata_o(mem_wdata_o), .mem_wstrb_o(mem_wstrb_o)
   );

endmodule

/* testbench/ext_mem_asserts.sv */
`timescale 1ns/1ps

module ext_mem_asserts (
   input logic               clk_i,
   input logic               arst_i,
   input logic [1:0]         m_req_i,
   input logic [1:0]         m_ack_i,   // Acks steered back to the masters
   input logic               gnt_i,     // Master holding the memory port
   input logic               mem_req_i,
   input logic               mem_ack_i,
   input ext_mem_pkg::addr_t mem_addr_i,
   input ext_mem_pkg::word_t mem_wdata_i,
   input ext_mem_pkg::strb_t mem_wstrb_i
);
   import ext_mem_pkg::*;

   // Fields frozen while waiting on the memory
   a_hold: assert property (@(posedge clk_i) disable iff (arst_i)
      mem_req_i && !mem_ack_i |=> mem_req_i && $stable(mem_addr_i) &&
      $stable(mem_wdata_i) && $stable(mem_wstrb_i))
      else $error("memory request changed or dropped before its ack");

   // The single owner keeps requesting for the whole transfer
   a_one_grant: assert property (@(posedge clk_i) disable iff (arst_i)
      mem_req_i |-> m_req_i[gnt_i])
      else $error("memory port held by a master that is not requesting");

   a_master_ack: assert property (@(posedge clk_i) disable iff (arst_i)
      (m_ack_i & ~m_req_i) == 2'b00)
      else $error("master ack without a request from that master");

endmodule

bind be_merge ext_mem_asserts u_asserts (
   .clk_i(clk_i), .arst_i(arst_i),
   .m_req_i(m_req_i), .m_ack_i(m_ack_o), .gnt_i(gnt_q),
   .mem_req_i(mem_req_o), .mem_ack_i(mem_ack_i),
   .mem_addr_i(mem_addr_o), .mem_wdata_i(mem_wdata_o), .mem_wstrb_i(mem_wstrb_o)
);

/* testbench/ext_mem_checker.sv */
`timescale 1ns/1ps

module ext_mem_checker #(
   parameter int NLINES_W = 4  // Must match the DUT caches
) (
   input logic               clk_i,
   input logic               arst_i,
   input logic               invalidate_i,
   input logic               i_req_i,
   input ext_mem_pkg::addr_t i_addr_i,
   input logic               i_ready_i,
   input logic               i_rvalid_i,
   input ext_mem_pkg::word_t i_rdata_i,
   input ext_mem_pkg::word_t i_exp_i,   // Expected word from the vector file
   input logic               d_req_i,
   input ext_mem_pkg::addr_t d_addr_i,
   input ext_mem_pkg::word_t d_wdata_i,
   input ext_mem_pkg::strb_t d_wstrb_i,
   input logic               d_ready_i,
   input logic               d_rvalid_i,
   input ext_mem_pkg::word_t d_rdata_i,
   input ext_mem_pkg::word_t d_exp_i,
   input logic               mem_req_i,
   input logic               mem_ack_i,
   input ext_mem_pkg::strb_t mem_wstrb_i
);
   import ext_mem_pkg::*;

   localparam int NLINES = 1 << NLINES_W;
   localparam int NWORDS = 1 << (ADDR_W - 2);

   word_t shadow [NWORDS];       // Expected memory contents
   addr_t line_tag [2][NLINES];  // Model of what each cache holds
   logic  line_ok [2][NLINES];
   int    tests, errors, exp_rd, mem_rd, mem_wr, fe_wr;
   logic  seen_req;

   // Same fill rule as the memory model
   function automatic word_t init_word(input addr_t a);
      return {a ^ 16'hc3a5, a + 16'h1234};
   endfunction

   initial begin
      for (int w = 0; w < NWORDS; w++) shadow[w] = init_word(addr_t'(w << 2));
      for (int l = 0; l < NLINES; l++) begin
         line_ok[0][l] = 1'b0;
         line_ok[1][l] = 1'b0;
      end
      {tests, errors, exp_rd, mem_rd, mem_wr, fe_wr} = '0;
      seen_req = 1'b0;
   end

   task automatic check_read(input int p, input addr_t a, input word_t rd, input logic rv,
                             input word_t vexp);
      string                nm;
      word_t                pred;
      logic [NLINES_W-1:0]  idx;
      int                   e0;
      nm   = (p == 0) ? "i" : "d";
      pred = shadow[a[ADDR_W-1:2]];
      idx  = a[NLINES_W+1:2];
      e0   = errors;
      if (!(line_ok[p][idx] && line_tag[p][idx] == {a[ADDR_W-1:2], 2'b00})) begin
         exp_rd++;  // Line not held, so a fill must reach memory
         line_ok[p][idx]  = 1'b1;
         line_tag[p][idx] = {a[ADDR_W-1:2], 2'b00};
      end
      if (!rv) begin
         $display("error %s_rvalid_o got 0 exp 1", nm);
         errors++;
      end
      if (rd !== pred) begin
         $display("error %s_rdata_o addr %h got %h exp %h", nm, a, rd, pred);
         errors++;
      end
      if (vexp !== pred) begin
         $display("vector for %s read at %h expects %h but memory holds %h", nm, a, vexp, pred);
         errors++;
      end
      tests++;
      $display("test %0d %s read  %h -> %h %s", tests, nm, a, rd, (errors == e0) ? "ok" : "bad");
   endtask

   always @(posedge clk_i) begin
      if (!arst_i) begin
         if (i_req_i || d_req_i) seen_req = 1'b1;
         if (mem_req_i && !seen_req) begin
            $display("memory request raised before any front-end request");
            errors++;
         end
         if (i_ready_i && !i_req_i) begin
            $display("i port ready without a pending request");
            errors++;
         end
         if (d_ready_i && !d_req_i) begin
            $display("d port ready without a pending request");
            errors++;
         end
         if (mem_req_i && mem_ack_i) begin
            if (mem_wstrb_i != '0) mem_wr++;
            else mem_rd++;
         end
         if (invalidate_i) begin
            for (int l = 0; l < NLINES; l++) begin
               line_ok[0][l] = 1'b0;
               line_ok[1][l] = 1'b0;
            end
         end
         if (i_ready_i) check_read(0, i_addr_i, i_rdata_i, i_rvalid_i, i_exp_i);
         if (d_ready_i) begin
            if (d_wstrb_i != '0) begin
               for (int b = 0; b < DATA_W/8; b++) begin
                  if (d_wstrb_i[b]) shadow[d_addr_i[ADDR_W-1:2]][8*b +: 8] = d_wdata_i[8*b +: 8];
               end
               fe_wr++;
               tests++;
               if (d_rvalid_i) begin
                  $display("error d_rvalid_o got 1 exp 0");
                  errors++;
               end
               $display("test %0d d write %h <- %h strb %h", tests, d_addr_i, d_wdata_i,
                        d_wstrb_i);
            end else begin
               check_read(1, d_addr_i, d_rdata_i, d_rvalid_i, d_exp_i);
            end
         end
      end
   end

   // Final tally of bus traffic against the model
   task report(output int errs);
      if (mem_rd != exp_rd) begin
         $display("memory saw %0d reads but the cache model expects %0d", mem_rd, exp_rd);
         errors++;
      end
      if (mem_wr != fe_wr) begin
         $display("memory saw %0d writes but the data port issued %0d", mem_wr, fe_wr);
         errors++;
      end
      $display("tests %0d, errors %0d, memory reads %0d, memory writes %0d",
               tests, errors, mem_rd, mem_wr);
      errs = errors;
   endtask

endmodule

/* testbench/tb_ext_mem.sv */
`timescale 1ns/1ps

module tb_ext_mem;
   import ext_mem_pkg::*;

   localparam int NLINES_W = 4;
   localparam int MAX_VEC  = 64;
   localparam int NWORDS   = 1 << (ADDR_W - 2);

   logic  clk_i = 1'b0;
   logic  arst_i, invalidate_i;
   logic  i_req_i, i_ready_o, i_rvalid_o;
   logic  d_req_i, d_ready_o, d_rvalid_o;
   addr_t i_addr_i, d_addr_i, mem_addr_o;
   word_t i_rdata_o, d_wdata_i, d_rdata_o, mem_wdata_o, mem_rdata_i;
   strb_t d_wstrb_i, mem_wstrb_o;
   logic  mem_req_o, mem_ack_i;
   word_t i_exp, d_exp;

   logic [87:0] vec [MAX_VEC];  // port, addr, strb, wdata, expected
   word_t       mem [NWORDS];
   int          nvec, limit, cycles, nerr, wait_cnt;
   int          seed = 32'h97be_9549;
   int          arrive [2];
   int          release_cnt;
   logic        armed;

   always #2 clk_i = ~clk_i;

   function automatic word_t init_word(input addr_t a);
      return {a ^ 16'hc3a5, a + 16'h1234};
   endfunction

   ext_mem #(.NLINES_W(NLINES_W)) i_ext_mem (
      .clk_i(clk_i), .arst_i(arst_i), .invalidate_i(invalidate_i),
      .i_req_i(i_req_i), .i_addr_i(i_addr_i),
      .i_ready_o(i_ready_o), .i_rvalid_o(i_rvalid_o), .i_rdata_o(i_rdata_o),
      .d_req_i(d_req_i), .d_addr_i(d_addr_i), .d_wdata_i(d_wdata_i), .d_wstrb_i(d_wstrb_i),
      .d_ready_o(d_ready_o), .d_rvalid_o(d_rvalid_o), .d_rdata_o(d_rdata_o),
      .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o),
      .mem_wstrb_o(mem_wstrb_o), .mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i)
   );

   ext_mem_checker #(.NLINES_W(NLINES_W)) u_checker (
      .clk_i(clk_i), .arst_i(arst_i), .invalidate_i(invalidate_i),
      .i_req_i(i_req_i), .i_addr_i(i_addr_i), .i_ready_i(i_ready_o),
      .i_rvalid_i(i_rvalid_o), .i_rdata_i(i_rdata_o), .i_exp_i(i_exp),
      .d_req_i(d_req_i), .d_addr_i(d_addr_i), .d_wdata_i(d_wdata_i), .d_wstrb_i(d_wstrb_i),
      .d_ready_i(d_ready_o), .d_rvalid_i(d_rvalid_o), .d_rdata_i(d_rdata_o), .d_exp_i(d_exp),
      .mem_req_i(mem_req_o), .mem_ack_i(mem_ack_i), .mem_wstrb_i(mem_wstrb_o)
   );

   // Memory model acks 1 to 4 cycles after the request on the falling edge
   always @(negedge clk_i) begin
      if (arst_i) begin
         mem_ack_i = 1'b0;
         armed     = 1'b0;
      end else if (mem_ack_i) begin
         mem_ack_i = 1'b0;
         armed     = 1'b0;
      end else if (mem_req_o) begin
         if (!armed) begin
            armed    = 1'b1;
            wait_cnt = $random(seed) & 3;
         end
         if (wait_cnt == 0) begin
            mem_ack_i   = 1'b1;
            mem_rdata_i = mem[mem_addr_o[ADDR_W-1:2]];
            for (int b = 0; b < DATA_W/8; b++) begin
               if (mem_wstrb_o[b]) mem[mem_addr_o[ADDR_W-1:2]][8*b +: 8] = mem_wdata_o[8*b +: 8];
            end
         end else begin
            wait_cnt--;
         end
      end
   end

   // Run limit scales with the vector count
   always @(posedge clk_i) begin
      cycles++;
      if (limit > 0 && cycles >= limit) begin
         $display("timeout: accesses still open after %0d cycles", cycles);
         $display("Checks failed");
         $finish;
      end
   end

   // One access held until ready is seen at a rising edge
   task automatic do_access(input int p, input logic [87:0] v);
      if (p == 0) begin
         i_req_i  = 1'b1;
         i_addr_i = v[83:68];
         i_exp    = v[31:0];
         @(posedge clk_i);
         while (!i_ready_o) @(posedge clk_i);
         @(negedge clk_i);
         i_req_i = 1'b0;
      end else begin
         d_req_i   = 1'b1;
         d_addr_i  = v[83:68];
         d_wstrb_i = v[67:64];
         d_wdata_i = v[63:32];
         d_exp     = v[31:0];
         @(posedge clk_i);
         while (!d_ready_o) @(posedge clk_i);
         @(negedge clk_i);
         d_req_i   = 1'b0;
         d_wstrb_i = '0;
      end
   endtask

   // Walk the vectors for one port; port 2 lines are barriers
   task automatic run_port(input int p);
      for (int k = 0; k < nvec; k++) begin
         if (vec[k][87:84] == 4'h2) begin
            arrive[p]++;
            if (p == 0) begin
               wait (arrive[1] >= arrive[0]);
               if (vec[k][64]) begin
                  invalidate_i = 1'b1;
                  @(negedge clk_i);
                  invalidate_i = 1'b0;
               end
               release_cnt++;
            end else begin
               wait (release_cnt >= arrive[1]);
            end
         end else if (vec[k][87:84] == 4'(p)) begin
            do_access(p, vec[k]);
         end
      end
   endtask

   initial begin
      arst_i       = 1'b1;
      invalidate_i = 1'b0;
      i_req_i      = 1'b0;
      i_addr_i     = '0;
      d_req_i      = 1'b0;
      d_addr_i     = '0;
      d_wdata_i    = '0;
      d_wstrb_i    = '0;
      mem_ack_i    = 1'b0;
      mem_rdata_i  = '0;
      i_exp        = '0;
      d_exp        = '0;
      {cycles, limit, nvec, release_cnt} = '0;
      arrive[0] = 0;
      arrive[1] = 0;
      for (int w = 0; w < NWORDS; w++) mem[w] = init_word(addr_t'(w << 2));
      for (int k = 0; k < MAX_VEC; k++) vec[k] = '1;
      $readmemh("testbench/ext_mem_vectors.hex", vec);
      while (nvec < MAX_VEC && vec[nvec][87:84] != 4'hf) nvec++;  // f marks the end
      limit = 40 * nvec + 100;
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      arst_i = 1'b0;
      repeat (10) @(negedge clk_i);  // Idle window, nothing may move
      fork
         run_port(0);
         run_port(1);
      join
      repeat (5) @(negedge clk_i);
      u_checker.report(nerr);
      if (nerr == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

/* build.f */
hw/ext_mem_pkg.sv
hw/fe_port.sv
hw/dm_cache.sv
hw/be_merge.sv
hw/ext_mem.sv
testbench/ext_mem_asserts.sv
testbench/ext_mem_checker.sv
testbench/tb_ext_mem.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module ext_mem
	verilator --lint-only --timing -f build.f --top-module tb_ext_mem

sim:
	verilator --binary --timing --assert -f build.f --top-module tb_ext_mem -Mdir obj_dir
	./obj_dir/Vtb_ext_mem | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* testbench/ext_mem_vectors.hex */
// port addr strb wdata expected, port 0 is i, 1 is d, 2 is a barrier (strb 1 pulses invalidate)
// a line with port f ends the list
0_0100_0_00000000_c2a51334
1_0200_0_00000000_c1a51434
0_0100_0_00000000_c2a51334
1_0200_0_00000000_c1a51434
0_0104_0_00000000_c2a11338
1_0204_0_00000000_c1a11438
2_0000_0_00000000_00000000
1_0200_3_aabbccdd_00000000
1_0200_0_00000000_c1a5ccdd
1_0300_c_11223344_00000000
1_0300_0_00000000_11221534
1_0300_5_55667788_00000000
1_0300_0_00000000_11661588
0_0104_0_00000000_c2a11338
0_0108_0_00000000_c2ad133c
2_0000_0_00000000_00000000
0_0400_0_00000000_c7a51634
2_0000_0_00000000_00000000
1_0400_f_deadbeef_00000000
1_0400_0_00000000_deadbeef
2_0000_1_00000000_00000000
0_0400_0_00000000_deadbeef
1_0200_0_00000000_c1a5ccdd
f_0000_0_00000000_00000000
